// File: Makefile
TOP = tb_cpu_top

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build output"
	@echo "make help   show this list"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) \
		-Mdir obj_dir -f list.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

// File: list.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/reg_file.sv
source/cpu_ctrl.sv
source/alu.sv
source/hazard_unit.sv
source/cpu_top.sv
tb/tb_cpu_top.sv

// File: source/alu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu (
	input pipe_pkg::alu_op_t op,
	input isa_pkg::word_t a,
	input isa_pkg::word_t b,
	output isa_pkg::word_t result,
	output logic zero
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int MSB = `CPU_XLEN - 1;

	word_t diff;
	logic lt_signed;

	assign diff = a - b;

	// signs differ: the negative one is smaller, else the difference tells
	assign lt_signed = (a[MSB] != b[MSB]) ? a[MSB] : diff[MSB];

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = {{MSB{1'b0}}, lt_signed};
			ALU_PASS_B: result = b;
			default: result = a + b;
		endcase
	end

	// branches run ALU_SUB, so zero means equal
	assign zero = (result == '0);

endmodule

// File: source/cpu_ctrl.sv
`timescale 1ns/1ps

module cpu_ctrl (
	input isa_pkg::word_t instr,
	output pipe_pkg::alu_op_t alu_op,
	output logic alu_src_imm,
	output logic reg_we,
	output logic mem_re,
	output logic mem_we,
	output pipe_pkg::wb_sel_t wb_sel,
	output logic is_branch,
	output logic branch_ne,
	output logic is_jump,
	output isa_pkg::word_t imm
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;

	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];

	// immediate formats, all sign extended from bit 31
	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// no-op unless an opcode below claims it
		alu_op = ALU_ADD;
		alu_src_imm = 1'b0;
		reg_we = 1'b0;
		mem_re = 1'b0;
		mem_we = 1'b0;
		wb_sel = WB_ALU;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		is_jump = 1'b0;
		imm = '0;
		case (opcode)
			OP: begin
				reg_we = 1'b1;
				case (funct3)
					F3_ADD_SUB: alu_op = instr[30] ? ALU_SUB : ALU_ADD;
					F3_AND: alu_op = ALU_AND;
					F3_OR: alu_op = ALU_OR;
					F3_XOR: alu_op = ALU_XOR;
					F3_SLT: alu_op = ALU_SLT;
					default: reg_we = 1'b0; // shifts, sltu not built
				endcase
			end
			OP_IMM: begin
				if (funct3 == F3_ADD_SUB) begin // addi only
					reg_we = 1'b1;
					alu_src_imm = 1'b1;
					imm = imm_i;
				end
			end
			LUI: begin
				reg_we = 1'b1;
				alu_src_imm = 1'b1;
				alu_op = ALU_PASS_B;
				imm = imm_u;
			end
			LOAD: begin
				reg_we = 1'b1;
				mem_re = 1'b1;
				alu_src_imm = 1'b1; // address = rs1 + imm
				wb_sel = WB_MEM;
				imm = imm_i;
			end
			STORE: begin
				mem_we = 1'b1;
				alu_src_imm = 1'b1;
				imm = imm_s;
			end
			BRANCH: begin
				if ((funct3 == F3_BEQ) || (funct3 == F3_BNE)) begin
					is_branch = 1'b1;
					branch_ne = (funct3 == F3_BNE);
					alu_op = ALU_SUB; // compare via zero flag
					imm = imm_b;
				end
			end
			JAL: begin
				is_jump = 1'b1;
				reg_we = 1'b1;
				wb_sel = WB_PC4;
				imm = imm_j;
			end
			default: ;
		endcase
	end

endmodule

// File: source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and address width
`define CPU_XLEN 32

// architectural registers, x0 included
`define CPU_NREGS 32

// first instruction address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// File: source/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_top (
	output logic inst_cyc_out,
	output logic inst_stb_out,
	output isa_pkg::word_t inst_addr_out,
	input logic inst_ack_in,
	input isa_pkg::word_t inst_data_in,
	output logic data_stb_out,
	output logic data_we_out,
	input logic data_ack_in,
	output isa_pkg::word_t data_addr_out,
	output isa_pkg::word_t data_data_out,
	input isa_pkg::word_t data_data_in,
	input logic sys_clk,
	input logic sys_rst
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam word_t PC_STEP = word_t'(4);

	typedef enum logic [1:0] {F_IDLE, F_WAIT, F_HOLD} fetch_state_t;

	fetch_state_t f_state;
	word_t pc;         // address of the outstanding or held fetch
	word_t hold_instr;
	word_t redir_pc;
	logic kill_f;      // outstanding fetch belongs to a flushed path
	logic f_valid;
	logic f_take;
	logic d_load;
	logic redirect;
	word_t f_instr;

	logic valid_d;
	word_t instr_d, pc_d, rdata_a_d, rdata_b_d, imm_d;
	alu_op_t alu_op_d;
	wb_sel_t wb_sel_d;
	logic alu_src_imm_d, reg_we_d, mem_re_d, mem_we_d, is_branch_d, branch_ne_d, is_jump_d;

	logic valid_e;
	word_t pc_e, imm_e, rdata_a_e, rdata_b_e;
	reg_idx_t rs1_e, rs2_e, rd_e;
	alu_op_t alu_op_e;
	wb_sel_t wb_sel_e;
	logic alu_src_imm_e, reg_we_e, mem_re_e, mem_we_e, is_branch_e, branch_ne_e, is_jump_e;
	word_t opa_e, opb_e, alu_res_e, target_e, pc4_e;
	logic zero_e, taken_e;

	logic valid_m;
	word_t alu_m, store_m, pc4_m, fwd_val_m;
	reg_idx_t rd_m;
	wb_sel_t wb_sel_m;
	logic reg_we_m, mem_re_m, mem_we_m;

	logic valid_w;
	word_t alu_w, mem_w, pc4_w, wb_data;
	reg_idx_t rd_w;
	wb_sel_t wb_sel_w;
	logic reg_we_w;

	fwd_sel_t fwd_a, fwd_b;
	logic stall_f, stall_d, flush_d, flush_e, freeze, inst_wait, data_wait;

	// strobe held until ack and a redirect during a wait kills that fetch
	assign inst_stb_out = (f_state == F_WAIT);
	assign inst_cyc_out = inst_stb_out;
	assign inst_addr_out = pc;
	assign f_valid = (f_state == F_HOLD) | (inst_stb_out & inst_ack_in & ~kill_f);
	assign f_instr = (f_state == F_HOLD) ? hold_instr : inst_data_in;
	assign f_take = f_valid & ~freeze & ~flush_d & ~stall_f;
	assign d_load = f_take & ~stall_d; // decode register takes the fetched word
	assign inst_wait = ~f_valid;
	assign redirect = taken_e & ~freeze;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			f_state <= F_IDLE;
			pc <= `CPU_RESET_PC;
			kill_f <= 1'b0;
		end else begin
			case (f_state)
				F_IDLE: f_state <= F_WAIT;
				F_WAIT: begin
					if (inst_ack_in) begin
						if (kill_f) begin
							pc <= redir_pc;
							kill_f <= 1'b0;
						end else if (redirect) begin
							pc <= target_e;
						end else if (f_take) begin
							pc <= pc + PC_STEP;
						end else begin
							f_state <= F_HOLD; // decode busy so park the word
						end
					end else if (redirect) begin
						kill_f <= 1'b1;
					end
				end
				F_HOLD: begin
					if (redirect) begin
						pc <= target_e;
						f_state <= F_WAIT;
					end else if (f_take) begin
						pc <= pc + PC_STEP;
						f_state <= F_WAIT;
					end
				end
				default: f_state <= F_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (inst_stb_out & inst_ack_in)
			hold_instr <= inst_data_in;
		if (redirect)
			redir_pc <= target_e;
	end

	// valid bits of the four pipeline registers
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid_d <= 1'b0;
			valid_e <= 1'b0;
			valid_m <= 1'b0;
			valid_w <= 1'b0;
		end else begin
			if (!freeze && flush_d)
				valid_d <= 1'b0;
			else if (d_load)
				valid_d <= 1'b1;
			if (!freeze) begin
				valid_e <= valid_d & ~flush_e;
				valid_m <= valid_e;
				valid_w <= valid_m;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (d_load) begin
			instr_d <= f_instr;
			pc_d <= pc;
		end
		if (!freeze) begin
			pc_e <= pc_d;
			imm_e <= imm_d;
			rdata_a_e <= rdata_a_d;
			rdata_b_e <= rdata_b_d;
			rs1_e <= instr_d[19:15];
			rs2_e <= instr_d[24:20];
			rd_e <= instr_d[11:7];
			alu_op_e <= alu_op_d;
			wb_sel_e <= wb_sel_d;
			alu_src_imm_e <= alu_src_imm_d;
			reg_we_e <= reg_we_d;
			mem_re_e <= mem_re_d;
			mem_we_e <= mem_we_d;
			is_branch_e <= is_branch_d;
			branch_ne_e <= branch_ne_d;
			is_jump_e <= is_jump_d;
			alu_m <= alu_res_e;
			store_m <= opb_e; // sw data after forwarding
			pc4_m <= pc4_e;
			rd_m <= rd_e;
			wb_sel_m <= wb_sel_e;
			reg_we_m <= reg_we_e;
			mem_re_m <= mem_re_e;
			mem_we_m <= mem_we_e;
			alu_w <= alu_m;
			mem_w <= data_data_in; // ack cycle of a load
			pc4_w <= pc4_m;
			rd_w <= rd_m;
			wb_sel_w <= wb_sel_m;
			reg_we_w <= reg_we_m;
		end
	end

	function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf_val, word_t m_val, word_t w_val);
		case (sel)
			FWD_MEM: return m_val;
			FWD_WB: return w_val;
			default: return rf_val;
		endcase
	endfunction

	// execute
	assign opa_e = fwd_mux(fwd_a, rdata_a_e, fwd_val_m, wb_data);
	assign opb_e = fwd_mux(fwd_b, rdata_b_e, fwd_val_m, wb_data);
	assign target_e = pc_e + imm_e; // branch and jal target
	assign pc4_e = pc_e + PC_STEP;
	assign taken_e = valid_e & (is_jump_e | (is_branch_e & (zero_e ^ branch_ne_e)));

	// memory stage with one acknowledged strobe per access
	assign data_stb_out = valid_m & (mem_re_m | mem_we_m);
	assign data_we_out = valid_m & mem_we_m;
	assign data_addr_out = alu_m;
	assign data_data_out = store_m;
	assign data_wait = data_stb_out & ~data_ack_in;
	assign fwd_val_m = (wb_sel_m == WB_PC4) ? pc4_m : alu_m;

	always_comb begin
		case (wb_sel_w)
			WB_MEM: wb_data = mem_w;
			WB_PC4: wb_data = pc4_w;
			default: wb_data = alu_w;
		endcase
	end

	cpu_ctrl u_ctrl (
		.instr(instr_d), .alu_op(alu_op_d), .alu_src_imm(alu_src_imm_d),
		.reg_we(reg_we_d), .mem_re(mem_re_d), .mem_we(mem_we_d), .wb_sel(wb_sel_d),
		.is_branch(is_branch_d), .branch_ne(branch_ne_d), .is_jump(is_jump_d), .imm(imm_d)
	);

	reg_file u_regs (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.rd_addr_a(instr_d[19:15]), .rd_addr_b(instr_d[24:20]),
		.rd_data_a(rdata_a_d), .rd_data_b(rdata_b_d),
		.wr_en(valid_w & reg_we_w), .wr_addr(rd_w), .wr_data(wb_data)
	);

	alu u_alu (
		.op(alu_op_e), .a(opa_e), .b(alu_src_imm_e ? imm_e : opb_e),
		.result(alu_res_e), .zero(zero_e)
	);

	hazard_unit u_hazard (
		.rs1_d(instr_d[19:15]), .rs2_d(instr_d[24:20]),
		.rs1_e(rs1_e), .rs2_e(rs2_e), .rd_e(rd_e), .rd_m(rd_m), .rd_w(rd_w),
		.reg_we_m(valid_m & reg_we_m), .reg_we_w(valid_w & reg_we_w),
		.mem_re_e(valid_e & mem_re_e), .taken_e(taken_e),
		.inst_wait(inst_wait), .data_wait(data_wait),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .stall_f(stall_f), .stall_d(stall_d),
		.flush_d(flush_d), .flush_e(flush_e), .freeze(freeze)
	);

endmodule

// File: source/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
	input isa_pkg::reg_idx_t rs1_d,
	input isa_pkg::reg_idx_t rs2_d,
	input isa_pkg::reg_idx_t rs1_e,
	input isa_pkg::reg_idx_t rs2_e,
	input isa_pkg::reg_idx_t rd_e,
	input isa_pkg::reg_idx_t rd_m,
	input isa_pkg::reg_idx_t rd_w,
	input logic reg_we_m,
	input logic reg_we_w,
	input logic mem_re_e,
	input logic taken_e,
	input logic inst_wait,
	input logic data_wait,
	output pipe_pkg::fwd_sel_t fwd_a,
	output pipe_pkg::fwd_sel_t fwd_b,
	output logic stall_f,
	output logic stall_d,
	output logic flush_d,
	output logic flush_e,
	output logic freeze
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic load_use;

	// newest producer first, x0 never forwarded
	function automatic fwd_sel_t pick_fwd(reg_idx_t src, reg_idx_t m_rd, logic m_we,
			reg_idx_t w_rd, logic w_we);
		if (m_we && (m_rd != '0) && (m_rd == src))
			return FWD_MEM;
		if (w_we && (w_rd != '0) && (w_rd == src))
			return FWD_WB;
		return FWD_NONE;
	endfunction

	assign fwd_a = pick_fwd(rs1_e, rd_m, reg_we_m, rd_w, reg_we_w);
	assign fwd_b = pick_fwd(rs2_e, rd_m, reg_we_m, rd_w, reg_we_w);

	// load result not ready before the next instruction's execute
	assign load_use = mem_re_e && (rd_e != '0) && ((rd_e == rs1_d) || (rd_e == rs2_d));

	assign freeze = data_wait; // whole pipe waits on the data bus
	assign stall_f = load_use;
	assign stall_d = load_use;

	// bubble into execute behind a load, or drop the instruction behind a taken transfer
	assign flush_e = ~data_wait & (taken_e | load_use);

	// fetch has nothing ready: decode gets a bubble unless it is being held
	assign flush_d = ~data_wait & (taken_e | (inst_wait & ~load_use));

endmodule

// File: source/isa_pkg.sv
package isa_pkg;

	// one data or address word
	typedef logic [31:0] word_t;

	// register number, x0..x31
	typedef logic [4:0] reg_idx_t;

	// funct3 field of an instruction
	typedef logic [2:0] funct3_t;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP     = 7'b0110011, // register-register alu
		OP_IMM = 7'b0010011, // addi only
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011, // lw
		STORE  = 7'b0100011, // sw
		BRANCH = 7'b1100011, // beq, bne
		JAL    = 7'b1101111
	} opcode_t;

	// alu group, bit 30 picks sub
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// branch group
	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;

endpackage

// File: source/pipe_pkg.sv
package pipe_pkg;

	// operation carried from decode into execute
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,    // also the branch compare
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,    // signed
		ALU_PASS_B  // lui, passes the immediate
	} alu_op_t;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		FWD_NONE, // value read in decode
		FWD_MEM,  // result sitting in memory stage
		FWD_WB    // result sitting in writeback
	} fwd_sel_t;

	// value written back to the register file
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4  // jal link
	} wb_sel_t;

endpackage

// File: source/reg_file.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module reg_file (
	input logic sys_clk,
	input logic sys_rst,
	input isa_pkg::reg_idx_t rd_addr_a,
	input isa_pkg::reg_idx_t rd_addr_b,
	output isa_pkg::word_t rd_data_a,
	output isa_pkg::word_t rd_data_b,
	input logic wr_en,
	input isa_pkg::reg_idx_t wr_addr,
	input isa_pkg::word_t wr_data
);
	import isa_pkg::*;

	word_t regs [`CPU_NREGS];

	// a write in flight wins over the stored value
	function automatic word_t read_port(reg_idx_t addr);
		if (addr == '0)
			return '0;
		if (wr_en && (wr_addr == addr))
			return wr_data;
		return regs[addr];
	endfunction

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data; // x0 stays zero
		end
	end

	assign rd_data_a = read_port(rd_addr_a);
	assign rd_data_b = read_port(rd_addr_b);

endmodule

// File: tb/cpu_patterns.mem
// first word is the program length, then one instruction word per line
// after the program, the store count, then one expected store per line as address data
0000001c
10000513 // 00 addi x10, x0, 256
00500093 // 04 addi x1, x0, 5
ff408113 // 08 addi x2, x1, -12
402081b3 // 0c sub  x3, x1, x2
00112233 // 10 slt  x4, x2, x1
00352023 // 14 sw   x3, 0(x10)
00452223 // 18 sw   x4, 4(x10)
123452b7 // 1c lui  x5, 0x12345
0022c333 // 20 xor  x6, x5, x2
00652423 // 24 sw   x6, 8(x10)
00852383 // 28 lw   x7, 8(x10)
0013f433 // 2c and  x8, x7, x1
005464b3 // 30 or   x9, x8, x5
00952623 // 34 sw   x9, 12(x10)
00318463 // 38 beq  x3, x3, +8 taken
04152023 // 3c sw   x1, 64(x10) skipped
00109463 // 40 bne  x1, x1, +8 falls through
002325b3 // 44 slt  x11, x6, x2
00b52823 // 48 sw   x11, 16(x10)
00209463 // 4c bne  x1, x2, +8 taken
04152023 // 50 sw   x1, 64(x10) skipped
0080066f // 54 jal  x12, +8
04152023 // 58 sw   x1, 64(x10) skipped
00c52a23 // 5c sw   x12, 20(x10)
00052683 // 60 lw   x13, 0(x10)
00c68733 // 64 add  x14, x13, x12
00e52c23 // 68 sw   x14, 24(x10)
0000006f // 6c jal  x0, 0 halt loop
00000007
00000100 0000000c
00000104 00000001
00000108 edcbaff9
0000010c 12345001
00000110 00000001
00000114 00000058
00000118 00000064

// File: tb/tb_cpu_top.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu_top;
	import isa_pkg::*;

	localparam int PAT_WORDS = 256;
	localparam int TIMEOUT_CYCLES = 5000;
	localparam int DRAIN_CYCLES = 40;
	localparam word_t NOP_WORD = 32'h0000_0013; // addi x0, x0, 0

	logic sys_clk = 1'b0;
	logic sys_rst = 1'b1;
	logic inst_cyc_out;
	logic inst_stb_out;
	word_t inst_addr_out;
	logic inst_ack_in = 1'b0;
	word_t inst_data_in = '0;
	logic data_stb_out;
	logic data_we_out;
	logic data_ack_in = 1'b0;
	word_t data_addr_out;
	word_t data_data_out;
	word_t data_data_in = '0;

	word_t pat [PAT_WORDS];  // program then expected stores
	word_t dmem [word_t];    // only locations written by stores
	int seed = 32'h258a;
	int prog_count = 0;
	int store_count = 0;
	int store_base = 0;
	int store_idx = 0;
	int check_count = 0;
	int error_count = 0;
	int inst_left = 0;       // cycles until the instruction ack
	int data_left = 0;
	int rst_edges = 0;
	int run_edges = 0;
	logic fetch_seen = 1'b0;
	logic run_error = 1'b0;

	cpu_top DUT (
		.inst_cyc_out(inst_cyc_out), .inst_stb_out(inst_stb_out),
		.inst_addr_out(inst_addr_out), .inst_ack_in(inst_ack_in),
		.inst_data_in(inst_data_in),
		.data_stb_out(data_stb_out), .data_we_out(data_we_out),
		.data_ack_in(data_ack_in), .data_addr_out(data_addr_out),
		.data_data_out(data_data_out), .data_data_in(data_data_in),
		.sys_clk(sys_clk), .sys_rst(sys_rst)
	);

	initial begin
		forever #5 sys_clk = ~sys_clk;
	end

	function automatic int draw_latency();
		return 1 + int'($unsigned($random(seed)) % 3); // 1 to 3 cycles
	endfunction

	function automatic word_t fetch_word(word_t addr);
		if ((addr[1:0] == 2'b00) && (addr < word_t'(prog_count) * 4))
			return pat[1 + int'(addr >> 2)];
		return NOP_WORD; // past the end of the program
	endfunction

	function automatic word_t fill_word(word_t addr);
		return addr ^ 32'h5a5a_c3c3;
	endfunction

	function automatic word_t load_word(word_t addr);
		if (dmem.exists(addr))
			return dmem[addr];
		return fill_word(addr);
	endfunction

	task automatic expect_strobes_low(string phase);
		check_count++;
		assert (!inst_cyc_out && !inst_stb_out && !data_stb_out && !data_we_out) else begin
			$display("FAIL %0t: bus request %s, cyc %b inst %b data %b we %b", $time, phase,
				inst_cyc_out, inst_stb_out, data_stb_out, data_we_out);
			error_count++;
		end
	endtask

	task automatic expect_cyc_with_stb();
		check_count++;
		assert (!inst_stb_out || inst_cyc_out) else begin
			$display("FAIL %0t: instruction strobe high with cyc low", $time);
			error_count++;
		end
	endtask

	task automatic watch_startup();
		if (run_edges == 0)
			expect_strobes_low("in the first cycle after reset");
		if (inst_stb_out && !fetch_seen) begin
			fetch_seen = 1'b1;
			check_count++;
			assert (inst_addr_out == `CPU_RESET_PC) else begin
				$display("FAIL %0t: first fetch at %h, expected %h", $time,
					inst_addr_out, `CPU_RESET_PC);
				error_count++;
			end
		end
		run_edges++;
	endtask

	task automatic compare_store(word_t addr, word_t data);
		word_t exp_addr;
		word_t exp_data;
		assert (store_idx < store_count) else begin
			$display("an extra store wrote %h to %h at %0t ns", data, addr, $time);
			error_count++;
		end
		if (store_idx < store_count) begin
			exp_addr = pat[store_base + 2 * store_idx];
			exp_data = pat[store_base + 2 * store_idx + 1];
			check_count++;
			assert ((addr == exp_addr) && (data == exp_data)) else begin
				$display("FAIL %0t: store %0d wrote %h to %h, expected %h to %h", $time,
					store_idx, data, addr, exp_data, exp_addr);
				error_count++;
			end
			store_idx++;
		end
	endtask

	// one ack per strobe and a strobe after an ack cycle is a new request
	task automatic serve_inst();
		if (inst_ack_in) begin
			inst_ack_in <= 1'b0;
		end else if (inst_stb_out) begin
			if (inst_left == 0)
				inst_left = draw_latency();
			inst_left--;
			if (inst_left == 0) begin
				inst_ack_in <= 1'b1;
				inst_data_in <= fetch_word(inst_addr_out);
			end
		end
	endtask

	task automatic serve_data();
		if (data_ack_in) begin
			data_ack_in <= 1'b0;
		end else if (data_stb_out) begin
			if (data_left == 0)
				data_left = draw_latency();
			data_left--;
			if (data_left == 0) begin
				data_ack_in <= 1'b1;
				if (data_we_out) begin
					compare_store(data_addr_out, data_data_out);
					dmem[data_addr_out] = data_data_out;
				end else begin
					data_data_in <= load_word(data_addr_out);
				end
			end
		end
	endtask

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			if (rst_edges > 0)
				expect_strobes_low("during reset"); // registers cleared by now
			rst_edges++;
			inst_left = 0;
			data_left = 0;
			inst_ack_in <= 1'b0;
			data_ack_in <= 1'b0;
		end else begin
			watch_startup();
			expect_cyc_with_stb();
			serve_inst();
			serve_data();
		end
	end

	initial begin : run
		int waited;
		waited = 0;
		$readmemh("tb/cpu_patterns.mem", pat);
		prog_count = int'(pat[0]);
		store_base = prog_count + 2;
		if ((prog_count < 1) || (prog_count > PAT_WORDS - 2)) begin
			$display("pattern file gives an unusable program length of %0d", prog_count);
			run_error = 1'b1;
		end else begin
			store_count = int'(pat[prog_count + 1]);
			if ((store_count < 1) || (store_base + 2 * store_count > PAT_WORDS)) begin
				$display("pattern file gives an unusable store count of %0d", store_count);
				run_error = 1'b1;
				store_count = 0;
			end
		end
		repeat (4) @(posedge sys_clk);
		sys_rst <= 1'b0;
		while ((store_idx < store_count) && (waited < TIMEOUT_CYCLES)) begin
			@(posedge sys_clk);
			waited++;
		end
		if (store_idx < store_count) begin
			$display("timeout: %0d of %0d stores seen after %0d cycles",
				store_idx, store_count, waited);
			run_error = 1'b1;
		end else begin
			repeat (DRAIN_CYCLES) @(posedge sys_clk); // stray stores still get flagged
		end
		$display("checks %0d, stores %0d of %0d, errors %0d", check_count, store_idx,
			store_count, error_count);
		if ((error_count == 0) && !run_error)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
